/* Bender.yml */
package:
  name: rv_decode

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/rv_isa_pkg.sv
      - rtl/rv_ctrl_pkg.sv
      - rtl/rv_decoder.sv
      - rtl/rv_regfile.sv
      - rtl/rv_id_stage.sv
      - rtl/rv_decode_top.sv
  - target: test
    files:
      - verif/tb_decode_top.sv

/* compile.f */
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/rv_ctrl_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_id_stage.sv
rtl/rv_decode_top.sv
verif/tb_decode_top.sv

/* rtl/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

    // operation the execute stage ALU performs.
    // ADD has code zero so that a bubble carries a harmless add.
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10
    } alu_op_e;

    // source of the value written back to rd.
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

endpackage

/* rtl/rv_decode_top.sv */
`timescale 1ns/1ns
`include "rv_defs.svh"

module rv_decode_top
    import rv_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inst_valid_i,
    input  logic [`RV_XLEN-1:0]   inst_i,
    input  logic [`RV_XLEN-1:0]   pc_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  logic                  wb_wen_i,
    input  logic [`RV_REG_AW-1:0] wb_rd_i,
    input  logic [`RV_XLEN-1:0]   wb_data_i,
    output logic                  ex_valid_o,
    output logic [`RV_REG_AW-1:0] ex_rd_o,
    output logic [`RV_XLEN-1:0]   ex_rs1_data_o,
    output logic [`RV_XLEN-1:0]   ex_rs2_data_o,
    output logic [`RV_XLEN-1:0]   ex_imm_o,
    output logic [`RV_XLEN-1:0]   ex_pc_o,
    output alu_op_e               ex_alu_op_o,
    output logic                  ex_alu_src_o,
    output wb_sel_e               ex_wb_sel_o,
    output logic                  ex_mem_wen_o,
    output logic                  ex_mem_ren_o,
    output logic                  ex_reg_wen_o,
    output logic                  ex_jal_o,
    output logic                  ex_jalr_o,
    output logic                  illegal_o,
    output logic                  branch_taken_o,
    output logic [`RV_XLEN-1:0]   branch_target_o
);

    rv_id_stage u_id_stage (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst_valid_i    (inst_valid_i),
        .inst_i          (inst_i),
        .pc_i            (pc_i),
        .stall_i         (stall_i),
        .flush_i         (flush_i),
        .wb_wen_i        (wb_wen_i),
        .wb_rd_i         (wb_rd_i),
        .wb_data_i       (wb_data_i),
        .ex_valid_o      (ex_valid_o),
        .ex_rd_o         (ex_rd_o),
        .ex_rs1_data_o   (ex_rs1_data_o),
        .ex_rs2_data_o   (ex_rs2_data_o),
        .ex_imm_o        (ex_imm_o),
        .ex_pc_o         (ex_pc_o),
        .ex_alu_op_o     (ex_alu_op_o),
        .ex_alu_src_o    (ex_alu_src_o),
        .ex_wb_sel_o     (ex_wb_sel_o),
        .ex_mem_wen_o    (ex_mem_wen_o),
        .ex_mem_ren_o    (ex_mem_ren_o),
        .ex_reg_wen_o    (ex_reg_wen_o),
        .ex_jal_o        (ex_jal_o),
        .ex_jalr_o       (ex_jalr_o),
        .illegal_o       (illegal_o),
        .branch_taken_o  (branch_taken_o),
        .branch_target_o (branch_target_o)
    );

endmodule

/* rtl/rv_decoder.sv */
`timescale 1ns/1ns
`include "rv_defs.svh"

module rv_decoder
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic [`RV_XLEN-1:0]   inst_i,
    output logic [`RV_REG_AW-1:0] rs1_o,
    output logic [`RV_REG_AW-1:0] rs2_o,
    output logic [`RV_REG_AW-1:0] rd_o,
    output logic [`RV_XLEN-1:0]   imm_o,
    output alu_op_e               alu_op_o,
    output logic                  alu_src_o,
    output wb_sel_e               wb_sel_o,
    output logic                  mem_wen_o,
    output logic                  mem_ren_o,
    output logic                  reg_wen_o,
    output logic                  jal_o,
    output logic                  jalr_o,
    output logic                  branch_o,
    output branch_f3_e            br_f3_o,
    output logic                  illegal_o
);

    opcode_e  opc;
    alu_f3_e  f3;
    imm_fmt_e fmt;

    // alt selects SUB over ADD and SRA over SRL.
    function automatic alu_op_e alu_from_f3(input alu_f3_e fn, input logic alt);
        alu_op_e op;
        case (fn)
            F3_ADD:  op = alt ? SUB : ADD;
            F3_SLL:  op = SLL;
            F3_SLT:  op = SLT;
            F3_SLTU: op = SLTU;
            F3_XOR:  op = XOR;
            F3_SR:   op = alt ? SRA : SRL;
            F3_OR:   op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    assign opc     = opcode_e'(inst_i[6:0]);
    assign f3      = alu_f3_e'(inst_i[14:12]);
    assign rd_o    = inst_i[11:7];
    assign rs1_o   = inst_i[19:15];
    assign rs2_o   = inst_i[24:20];
    assign br_f3_o = branch_f3_e'(inst_i[14:12]);

    always_comb begin
        fmt       = FMT_R;
        alu_op_o  = ADD;
        alu_src_o = 1'b0;
        wb_sel_o  = WB_ALU;
        mem_wen_o = 1'b0;
        mem_ren_o = 1'b0;
        reg_wen_o = 1'b0;
        jal_o     = 1'b0;
        jalr_o    = 1'b0;
        branch_o  = 1'b0;
        illegal_o = 1'b0;
        case (opc)
            OPC_LUI: begin
                fmt       = FMT_U;
                alu_op_o  = PASS_B;
                alu_src_o = 1'b1;
                reg_wen_o = 1'b1;
            end
            OPC_AUIPC: begin
                fmt       = FMT_U;
                alu_src_o = 1'b1;
                reg_wen_o = 1'b1;
            end
            OPC_JAL: begin
                fmt       = FMT_J;
                wb_sel_o  = WB_PC4;
                reg_wen_o = 1'b1;
                jal_o     = 1'b1;
            end
            OPC_JALR: begin
                fmt       = FMT_I;
                alu_src_o = 1'b1;
                wb_sel_o  = WB_PC4;
                reg_wen_o = 1'b1;
                jalr_o    = 1'b1;
            end
            OPC_BRANCH: begin
                fmt      = FMT_B;
                alu_op_o = SUB;
                branch_o = 1'b1;
            end
            OPC_LOAD: begin
                fmt       = FMT_I;
                alu_src_o = 1'b1;
                wb_sel_o  = WB_MEM;
                mem_ren_o = 1'b1;
                reg_wen_o = 1'b1;
            end
            OPC_STORE: begin
                fmt       = FMT_S;
                alu_src_o = 1'b1;
                mem_wen_o = 1'b1;
            end
            OPC_OPIMM: begin
                // only the shifts look at bit 30, so ADDI never turns into SUB.
                fmt       = FMT_I;
                alu_op_o  = alu_from_f3(f3, (f3 == F3_SR) && inst_i[30]);
                alu_src_o = 1'b1;
                reg_wen_o = 1'b1;
            end
            OPC_OP: begin
                alu_op_o  = alu_from_f3(f3, inst_i[30]);
                reg_wen_o = 1'b1;
            end
            default: illegal_o = 1'b1;
        endcase
    end

    always_comb begin
        case (fmt)
            FMT_I:   imm_o = {{20{inst_i[31]}}, inst_i[31:20]};
            FMT_S:   imm_o = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
            FMT_B:   imm_o = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                              inst_i[11:8], 1'b0};
            FMT_U:   imm_o = {inst_i[31:12], 12'b0};
            FMT_J:   imm_o = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                              inst_i[30:21], 1'b0};
            default: imm_o = '0;
        endcase
    end

endmodule

/* rtl/rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// width of the integer data path and of addresses.
`define RV_XLEN 32

// number of architectural registers, x0 included.
`define RV_NREGS 32

// width of a register index.
`define RV_REG_AW 5

// value the PC field of the ID/EX register takes after reset.
`define RV_RESET_PC 32'h0000_0000

`endif

/* rtl/rv_id_stage.sv */
`timescale 1ns/1ns
`include "rv_defs.svh"

module rv_id_stage
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inst_valid_i,
    input  logic [`RV_XLEN-1:0]   inst_i,
    input  logic [`RV_XLEN-1:0]   pc_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  logic                  wb_wen_i,
    input  logic [`RV_REG_AW-1:0] wb_rd_i,
    input  logic [`RV_XLEN-1:0]   wb_data_i,
    output logic                  ex_valid_o,
    output logic [`RV_REG_AW-1:0] ex_rd_o,
    output logic [`RV_XLEN-1:0]   ex_rs1_data_o,
    output logic [`RV_XLEN-1:0]   ex_rs2_data_o,
    output logic [`RV_XLEN-1:0]   ex_imm_o,
    output logic [`RV_XLEN-1:0]   ex_pc_o,
    output alu_op_e               ex_alu_op_o,
    output logic                  ex_alu_src_o,
    output wb_sel_e               ex_wb_sel_o,
    output logic                  ex_mem_wen_o,
    output logic                  ex_mem_ren_o,
    output logic                  ex_reg_wen_o,
    output logic                  ex_jal_o,
    output logic                  ex_jalr_o,
    output logic                  illegal_o,
    output logic                  branch_taken_o,
    output logic [`RV_XLEN-1:0]   branch_target_o
);

    logic [`RV_REG_AW-1:0] dec_rs1, dec_rs2, dec_rd;
    logic [`RV_XLEN-1:0]   dec_imm;
    alu_op_e               dec_alu_op;
    wb_sel_e               dec_wb_sel;
    branch_f3_e            dec_br_f3;
    logic                  dec_alu_src, dec_mem_wen, dec_mem_ren, dec_reg_wen;
    logic                  dec_jal, dec_jalr, dec_branch, dec_illegal;
    logic [`RV_XLEN-1:0]   rs1_data, rs2_data;
    logic                  cmp_true;
    logic [`RV_XLEN-1:0]   tgt_sum;
    logic                  load_ctrl;

    rv_decoder u_decoder (
        .inst_i    (inst_i),
        .rs1_o     (dec_rs1),
        .rs2_o     (dec_rs2),
        .rd_o      (dec_rd),
        .imm_o     (dec_imm),
        .alu_op_o  (dec_alu_op),
        .alu_src_o (dec_alu_src),
        .wb_sel_o  (dec_wb_sel),
        .mem_wen_o (dec_mem_wen),
        .mem_ren_o (dec_mem_ren),
        .reg_wen_o (dec_reg_wen),
        .jal_o     (dec_jal),
        .jalr_o    (dec_jalr),
        .branch_o  (dec_branch),
        .br_f3_o   (dec_br_f3),
        .illegal_o (dec_illegal)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_i    (dec_rs1),
        .rs2_i    (dec_rs2),
        .wen_i    (wb_wen_i),
        .rd_i     (wb_rd_i),
        .wdata_i  (wb_data_i),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    always_comb begin
        case (dec_br_f3)
            BR_EQ:   cmp_true = (rs1_data == rs2_data);
            BR_NE:   cmp_true = (rs1_data != rs2_data);
            BR_LT:   cmp_true = ($signed(rs1_data) < $signed(rs2_data));
            BR_GE:   cmp_true = ($signed(rs1_data) >= $signed(rs2_data));
            BR_LTU:  cmp_true = (rs1_data < rs2_data);
            BR_GEU:  cmp_true = (rs1_data >= rs2_data);
            default: cmp_true = 1'b0;
        endcase
    end

    // one adder serves both targets, JALR swaps the base and drops bit 0.
    assign tgt_sum         = (dec_jalr ? rs1_data : pc_i) + dec_imm;
    assign branch_target_o = {tgt_sum[`RV_XLEN-1:1], tgt_sum[0] & ~dec_jalr};
    assign branch_taken_o  = inst_valid_i && !stall_i &&
                             (dec_jal || dec_jalr || (dec_branch && cmp_true));

    // control only loads a live instruction, anything else leaves a bubble.
    assign load_ctrl = inst_valid_i && !flush_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid_o   <= 1'b0;
            ex_alu_op_o  <= ADD;
            ex_alu_src_o <= 1'b0;
            ex_wb_sel_o  <= WB_ALU;
            ex_mem_wen_o <= 1'b0;
            ex_mem_ren_o <= 1'b0;
            ex_reg_wen_o <= 1'b0;
            ex_jal_o     <= 1'b0;
            ex_jalr_o    <= 1'b0;
            illegal_o    <= 1'b0;
            ex_pc_o      <= `RV_RESET_PC;
        end else if (!stall_i) begin
            // an illegal opcode travels as an invalid slot that carries its flag.
            ex_valid_o   <= load_ctrl && !dec_illegal;
            ex_alu_op_o  <= load_ctrl ? dec_alu_op : ADD;
            ex_alu_src_o <= load_ctrl && dec_alu_src;
            ex_wb_sel_o  <= load_ctrl ? dec_wb_sel : WB_ALU;
            ex_mem_wen_o <= load_ctrl && dec_mem_wen;
            ex_mem_ren_o <= load_ctrl && dec_mem_ren;
            ex_reg_wen_o <= load_ctrl && dec_reg_wen;
            ex_jal_o     <= load_ctrl && dec_jal;
            ex_jalr_o    <= load_ctrl && dec_jalr;
            illegal_o    <= load_ctrl && dec_illegal;
            ex_pc_o      <= pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            ex_rd_o       <= dec_rd;
            ex_rs1_data_o <= rs1_data;
            ex_rs2_data_o <= rs2_data;
            ex_imm_o      <= dec_imm;
        end
    end

endmodule

/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

    // major opcodes of the supported RV32I subset.
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OPIMM  = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // funct3 of the conditional branches.
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_f3_e;

    // funct3 of the register and immediate ALU instructions.
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_f3_e;

    // immediate layouts, R meaning no immediate.
    typedef enum logic [2:0] {FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J} imm_fmt_e;

endpackage

/* rtl/rv_regfile.sv */
`timescale 1ns/1ns
`include "rv_defs.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`RV_REG_AW-1:0] rs1_i,
    input  logic [`RV_REG_AW-1:0] rs2_i,
    input  logic                  wen_i,
    input  logic [`RV_REG_AW-1:0] rd_i,
    input  logic [`RV_XLEN-1:0]   wdata_i,
    output logic [`RV_XLEN-1:0]   rdata1_o,
    output logic [`RV_XLEN-1:0]   rdata2_o
);

    // x0 has no storage, it is decoded as zero on the read side.
    logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];
    logic                wr_hit;

    assign wr_hit = wen_i && (rd_i != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // a write in flight to the same register is forwarded to the reader.
    always_comb begin
        if (rs1_i == '0) begin
            rdata1_o = '0;
        end else if (wr_hit && (rd_i == rs1_i)) begin
            rdata1_o = wdata_i;
        end else begin
            rdata1_o = regs[rs1_i];
        end
        if (rs2_i == '0) begin
            rdata2_o = '0;
        end else if (wr_hit && (rd_i == rs2_i)) begin
            rdata2_o = wdata_i;
        end else begin
            rdata2_o = regs[rs2_i];
        end
    end

endmodule

/* verif/tb_decode_top.sv */
`timescale 1ns/1ns
`include "rv_defs.svh"

module tb_decode_top
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
();

    localparam int N_RAND  = 400;
    // reset and idle cycles, register fill, bypass run and random run.
    localparam int N_ISSUE = 8 + 32 + 8 + N_RAND;

    // expected ID/EX contents.
    // alu_chk and dk mark the fields that have a defined expected value.
    typedef struct packed {
        logic valid, alu_src, mem_wen, mem_ren, reg_wen, jal, jalr, ill, alu_chk, dk;
        alu_op_e               alu_op;
        wb_sel_e               wb_sel;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   rs1, rs2, imm, pc;
    } ex_t;

    logic clk = 1'b0;
    logic rst_n, inst_valid_i, stall_i, flush_i, wb_wen_i;
    logic [`RV_XLEN-1:0] inst_i, pc_i, wb_data_i;
    logic [`RV_REG_AW-1:0] wb_rd_i;
    logic ex_valid_o, ex_alu_src_o, ex_mem_wen_o, ex_mem_ren_o, ex_reg_wen_o;
    logic ex_jal_o, ex_jalr_o, illegal_o, branch_taken_o;
    logic [`RV_REG_AW-1:0] ex_rd_o;
    logic [`RV_XLEN-1:0] ex_rs1_data_o, ex_rs2_data_o, ex_imm_o, ex_pc_o, branch_target_o;
    alu_op_e ex_alu_op_o;
    wb_sel_e ex_wb_sel_o;

    logic [`RV_XLEN-1:0] shadow [`RV_NREGS];
    logic [6:0] opcs [12] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                              OPC_LOAD, OPC_STORE, OPC_OPIMM, OPC_OP,
                              7'b0001111, 7'b1110011, 7'b0000000};
    ex_t cur, nxt;
    logic e_taken, e_tchk;
    logic [`RV_XLEN-1:0] e_target, w;
    logic [`RV_REG_AW-1:0] r;
    integer seed;
    int errors, k;

    rv_decode_top UUT (.*);

    always #20 clk = ~clk;

    function automatic logic [`RV_XLEN-1:0] read_reg(input logic [`RV_REG_AW-1:0] idx);
        if (idx == '0) return '0;
        if (wb_wen_i && wb_rd_i == idx) return wb_data_i;
        return shadow[idx];
    endfunction

    function automatic alu_op_e alu_of(input logic [2:0] f3, input logic b30, input logic is_reg);
        case (f3)
            3'd0: return (b30 && is_reg) ? SUB : ADD;
            3'd1: return SLL;
            3'd2: return SLT;
            3'd3: return SLTU;
            3'd4: return XOR;
            3'd5: return b30 ? SRA : SRL;
            3'd6: return OR;
            default: return AND;
        endcase
    endfunction

    function automatic logic br_cond(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
        case (f3)
            BR_EQ:  return a == b;
            BR_NE:  return a != b;
            BR_LT:  return $signed(a) < $signed(b);
            BR_GE:  return $signed(a) >= $signed(b);
            BR_LTU: return a < b;
            BR_GEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // reference decode of the inputs now on the pins.
    task automatic model();
        logic [6:0]  opc;
        logic [6:0]  fl;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic        live;
        opc  = inst_i[6:0];
        a    = read_reg(inst_i[19:15]);
        b    = read_reg(inst_i[24:20]);
        live = inst_valid_i && !flush_i;
        // flag bits are alu_src, mem_ren, mem_wen, reg_wen, jal, jalr, branch.
        case (opc)
            OPC_LUI, OPC_AUIPC, OPC_OPIMM: fl = 7'b1001000;
            OPC_JAL:    fl = 7'b0001100;
            OPC_JALR:   fl = 7'b1001010;
            OPC_BRANCH: fl = 7'b0000001;
            OPC_LOAD:   fl = 7'b1101000;
            OPC_STORE:  fl = 7'b1010000;
            OPC_OP:     fl = 7'b0001000;
            default:    fl = 7'b0;
        endcase
        case (opc)
            OPC_JALR, OPC_LOAD, OPC_OPIMM: imm = {{20{inst_i[31]}}, inst_i[31:20]};
            OPC_STORE:  imm = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
            OPC_BRANCH: imm = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC: imm = {inst_i[31:12], 12'h0};
            OPC_JAL:    imm = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
            default:    imm = '0;
        endcase
        nxt         = '0;
        nxt.dk      = 1'b1;
        nxt.rd      = inst_i[11:7];
        nxt.rs1     = a;
        nxt.rs2     = b;
        nxt.imm     = imm;
        nxt.pc      = pc_i;
        nxt.valid   = live && (fl != '0);
        nxt.ill     = live && (fl == '0);
        nxt.alu_chk = !live || (fl[2:0] == 3'b0);
        if (live) begin
            {nxt.alu_src, nxt.mem_ren, nxt.mem_wen, nxt.reg_wen, nxt.jal, nxt.jalr} = fl[6:1];
            if (fl[2] || fl[1]) nxt.wb_sel = WB_PC4;
            else if (fl[5]) nxt.wb_sel = WB_MEM;
            if (opc == OPC_LUI) nxt.alu_op = PASS_B;
            if (opc == OPC_OP || opc == OPC_OPIMM)
                nxt.alu_op = alu_of(inst_i[14:12], inst_i[30], opc == OPC_OP);
        end
        e_tchk   = fl[2] || fl[1] || fl[0];
        e_taken  = inst_valid_i && !stall_i &&
                   (fl[2] || fl[1] || (fl[0] && br_cond(inst_i[14:12], a, b)));
        e_target = fl[1] ? ((a + imm) & ~32'h1) : (pc_i + imm);
    endtask

    task automatic step(input logic v, input logic [31:0] inst, input logic st, input logic fl,
                        input logic we, input logic [4:0] rd, input logic [31:0] wd);
        @(posedge clk);
        #2;
        // the edge just passed loaded the bundle unless the stage was stalled.
        if (!stall_i) cur = nxt;
        inst_valid_i = v;
        inst_i       = inst;
        pc_i         = $random(seed) & 32'hffff_fffc;
        stall_i      = st;
        flush_i      = fl;
        wb_wen_i     = we;
        wb_rd_i      = rd;
        wb_data_i    = wd;
        model();
        if (we && rd != '0) shadow[rd] = wd;
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("ERROR %s expected %h actual %h at %0t ns", name, exp, act, $time);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            check("ex_valid_o", cur.valid, ex_valid_o);
            check("ex_alu_src_o", cur.alu_src, ex_alu_src_o);
            check("ex_mem_wen_o", cur.mem_wen, ex_mem_wen_o);
            check("ex_mem_ren_o", cur.mem_ren, ex_mem_ren_o);
            check("ex_reg_wen_o", cur.reg_wen, ex_reg_wen_o);
            check("ex_jal_o", cur.jal, ex_jal_o);
            check("ex_jalr_o", cur.jalr, ex_jalr_o);
            check("illegal_o", cur.ill, illegal_o);
            check("ex_wb_sel_o", cur.wb_sel, ex_wb_sel_o);
            check("ex_pc_o", cur.pc, ex_pc_o);
            check("branch_taken_o", e_taken, branch_taken_o);
            if (e_tchk) check("branch_target_o", e_target, branch_target_o);
            if (cur.alu_chk) begin
                check("ex_alu_op_o", cur.alu_op, ex_alu_op_o);
            end
            if (cur.dk) begin
                check("ex_rd_o", cur.rd, ex_rd_o);
                check("ex_rs1_data_o", cur.rs1, ex_rs1_data_o);
                check("ex_rs2_data_o", cur.rs2, ex_rs2_data_o);
                check("ex_imm_o", cur.imm, ex_imm_o);
            end
        end
    end

    initial begin
        #((N_ISSUE + 50) * 40);
        $display("timeout: the run did not finish within %0d cycles", N_ISSUE + 50);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        seed         = 32'he734;
        errors       = 0;
        rst_n        = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        stall_i      = 1'b0;
        flush_i      = 1'b0;
        wb_wen_i     = 1'b0;
        wb_rd_i      = '0;
        wb_data_i    = '0;
        foreach (shadow[i]) shadow[i] = '0;
        cur         = '0;
        cur.pc      = `RV_RESET_PC;
        cur.alu_chk = 1'b1;
        model();
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (2) step(1'b0, $random(seed), 1'b0, 1'b0, 1'b0, '0, '0);
        for (int i = 0; i < 32; i++) begin
            step(1'b0, $random(seed), 1'b0, 1'b0, 1'b1, i, $random(seed));
        end
        // each instruction reads the register that is written in the same cycle.
        repeat (8) begin
            r = 1 + ($unsigned($random(seed)) % 31);
            w = $random(seed);
            w[6:0] = OPC_OP;
            w[19:15] = r;
            step(1'b1, w, 1'b0, 1'b0, 1'b1, r, $random(seed));
        end
        repeat (N_RAND) begin
            w = $random(seed);
            k = $unsigned($random(seed)) % 12;
            w[6:0] = opcs[k];
            // equal operands now and then so that BEQ, BGE and BGEU are taken.
            if (k == 4 && w[25]) w[24:20] = w[19:15];
            r = $random(seed);
            step(($random(seed) & 7) != 0, w, ($random(seed) & 7) == 0,
                 ($random(seed) & 7) == 0, ($random(seed) & 3) == 0, r, $random(seed));
        end
        repeat (2) step(1'b0, '0, 1'b0, 1'b0, 1'b0, '0, '0);
        @(posedge clk);
        $display("checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
